/* logic/phy_config.svh */
`ifndef PHY_CONFIG_SVH
`define PHY_CONFIG_SVH

`default_nettype none

// K28.5 comma in line order, bit 0 sent first
// Form sent at negative running disparity, abcdei fghj = 001111 1010
`define PHY_COMMA_NEG 10'h17C
// Form sent at positive running disparity
`define PHY_COMMA_POS 10'h283

// Commas seen in one word phase before the aligner locks
`define PHY_LOCK_COMMAS 3

`default_nettype wire

`endif

/* logic/phy_pkg.sv */
`default_nettype none

package phy_pkg;

  // One data or control byte, HGF EDCBA
  typedef logic [7:0] byte_t;
  // Transmission character in line order, bit 0 goes out first
  typedef logic [9:0] code_t;
  // Running disparity, 1 for positive
  typedef logic rd_t;
  // Bit 0 code not in table, bit 1 disparity violation
  typedef logic [1:0] rx_status_t;
  // Sub-blocks in table order with a (or f) in the MSB
  typedef logic [5:0] sub6_t;
  typedef logic [3:0] sub4_t;

  typedef struct packed {
    byte_t data;
    logic  k;
  } tx_word_t;

  typedef struct packed {
    byte_t      data;
    logic       k;
    rx_status_t status;
  } rx_word_t;

  typedef enum logic [1:0] {
    HUNT,
    COUNT,
    LOCKED
  } align_state_t;

  //////////////////////////////////////////////////
  // 8b/10b tables, forms used at negative disparity
  //////////////////////////////////////////////////

  // 5b/6b for D.00 to D.31
  localparam sub6_t ENC6 [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
  };

  // 3b/4b for D.x.0 to D.x.P7
  localparam sub4_t ENC4_D [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };

  // 3b/4b for K.x.0 to K.x.7
  localparam sub4_t ENC4_K [8] = '{
    4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111
  };

  // K28 6b block and the alternate D.x.A7 block
  localparam sub6_t K28_6B  = 6'b001111;
  localparam sub4_t ALT7_4B = 4'b0111;

endpackage

`default_nettype wire

/* logic/enc_8b10b.sv */
`timescale 1ns/1ps
`default_nettype none

module enc_8b10b (
  input  logic              ref_clk,
  input  logic              rst,
  input  logic              word_tick,
  input  phy_pkg::tx_word_t tx_word,
  input  logic              idle,
  output phy_pkg::code_t    code
);
  import phy_pkg::*;

  rd_t        rd;
  rd_t        rd_mid;
  rd_t        rd_next;
  byte_t      din;
  logic [4:0] x;
  logic [2:0] y;
  logic       k;
  logic       alt7;
  logic       unbal6;
  logic       unbal4;
  logic       flip6;
  logic       flip4;
  sub6_t      s6;
  sub4_t      s4;
  logic [9:0] sym;

  //////////////////////////////////////////////////
  // Sub-block lookup
  //////////////////////////////////////////////////

  always_comb begin
    // Idle slot sends K28.5
    din = idle ? 8'hBC : tx_word.data;
    k   = idle | tx_word.k;
    x   = din[4:0];
    y   = din[7:5];

    // Only K28 has its own 6b block, Kx.7 reuse the data block
    s6     = (k && x == 5'd28) ? K28_6B : ENC6[x];
    unbal6 = $countones(s6) != 3;
    // D.07 flips even though balanced
    flip6  = rd && (unbal6 || x == 5'd7);
    rd_mid = rd ^ unbal6;

    // Alternate 7 avoids a run of five in e/i f/g/h
    alt7 = rd_mid ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
                  : (x == 5'd17 || x == 5'd18 || x == 5'd20);
    if (k) begin
      s4 = ENC4_K[y];
    end else if (y == 3'd7 && alt7) begin
      s4 = ALT7_4B;
    end else begin
      s4 = ENC4_D[y];
    end
    unbal4 = $countones(s4) != 2;
    // K blocks always follow disparity, D.x.3 flips as well
    flip4   = rd_mid && (k || unbal4 || y == 3'd3);
    rd_next = rd_mid ^ unbal4;

    sym  = {flip6 ? ~s6 : s6, flip4 ? ~s4 : s4};
    // a lands in bit 0
    code = {<<{sym}};
  end

  //////////////////////////////////////////////////
  // Running disparity, one step per word
  //////////////////////////////////////////////////

  always_ff @(posedge ref_clk) begin
    if (rst) begin
      rd <= 1'b0;
    end else if (word_tick) begin
      rd <= rd_next;
    end
  end

endmodule

`default_nettype wire

/* logic/tx_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_serializer (
  input  logic           ref_clk,
  input  logic           rst,
  input  phy_pkg::code_t code,
  output logic           word_tick,
  output logic           tx_out_p,
  output logic           tx_out_n
);
  import phy_pkg::*;

  logic [3:0] phase;
  code_t      shift_q;

  // Word phase 0 to 9, tick on the last bit slot
  assign word_tick = (phase == 4'd9);

  always_ff @(posedge ref_clk) begin
    if (rst) begin
      phase <= 4'd0;
    end else if (word_tick) begin
      phase <= 4'd0;
    end else begin
      phase <= phase + 4'd1;
    end
  end

  // Load on tick, then LSB first
  always_ff @(posedge ref_clk) begin
    if (rst) begin
      shift_q <= '0;
    end else if (word_tick) begin
      shift_q <= code;
    end else begin
      shift_q <= {1'b0, shift_q[9:1]};
    end
  end

  // Differential pair
  assign tx_out_p = shift_q[0];
  assign tx_out_n = ~shift_q[0];

endmodule

`default_nettype wire

/* logic/rx_aligner.sv */
`timescale 1ns/1ps
`include "phy_config.svh"
`default_nettype none

module rx_aligner (
  input  logic           ref_clk,
  input  logic           rst,
  input  logic           rx_in,
  input  logic           rx_polarity,
  output phy_pkg::code_t code,
  output logic           code_strobe,
  output logic           locked
);
  import phy_pkg::*;

  localparam int CntW = $clog2(`PHY_LOCK_COMMAS + 1);

  align_state_t    state;
  code_t           window;
  logic [3:0]      phase;
  logic [CntW-1:0] commas;
  logic            rx_bit;
  logic            comma_hit;
  logic            boundary;

  // Optional lane inversion
  assign rx_bit = rx_in ^ rx_polarity;

  // Newest bit enters at the top, so bit 0 is the oldest
  always_ff @(posedge ref_clk) begin
    if (rst) begin
      window <= '0;
    end else begin
      window <= {rx_bit, window[9:1]};
    end
  end

  assign comma_hit = (window == `PHY_COMMA_NEG) || (window == `PHY_COMMA_POS);
  assign boundary  = (phase == 4'd9);

  //////////////////////////////////////////////////
  // Lock FSM
  //////////////////////////////////////////////////

  always_ff @(posedge ref_clk) begin
    if (rst) begin
      state  <= HUNT;
      phase  <= 4'd0;
      commas <= '0;
    end else begin
      phase <= boundary ? 4'd0 : phase + 4'd1;
      case (state)
        HUNT: begin
          // Window holds a full word now, next one ten bits later
          if (comma_hit) begin
            phase  <= 4'd0;
            commas <= CntW'(1);
            state  <= COUNT;
          end
        end
        COUNT: begin
          if (comma_hit) begin
            if (!boundary) begin
              state <= HUNT;
            end else if (commas == CntW'(`PHY_LOCK_COMMAS - 1)) begin
              state <= LOCKED;
            end else begin
              commas <= commas + 1'b1;
            end
          end
        end
        LOCKED: begin
          // Comma off the word grid means the phase is lost
          if (comma_hit && !boundary) begin
            state <= HUNT;
          end
        end
        default: state <= HUNT;
      endcase
    end
  end

  assign locked      = (state == LOCKED);
  assign code        = window;
  assign code_strobe = locked && boundary;

endmodule

`default_nettype wire

/* logic/dec_8b10b.sv */
`timescale 1ns/1ps
`default_nettype none

module dec_8b10b (
  input  logic              ref_clk,
  input  logic              rst,
  input  phy_pkg::code_t    code,
  input  logic              code_strobe,
  output phy_pkg::rx_word_t rx_word,
  output logic              valid
);
  import phy_pkg::*;

  rd_t        rd;
  rd_t        rd_in;
  rd_t        rd_mid;
  rd_t        rd_next;
  logic       rd_known;
  logic [9:0] sym;
  sub6_t      s6;
  sub4_t      s4;
  int         ones6;
  int         ones4;
  logic [4:0] x;
  logic [2:0] y;
  logic       k28;
  logic       a7;
  logic       kx7;
  logic       d_a7;
  logic       hit6;
  logic       hit4;
  logic       disp_err6;
  logic       disp_err4;
  rx_word_t   word_d;

  // Back to table order, a in the MSB
  assign sym = {<<{code}};
  assign s6  = sym[9:4];
  assign s4  = sym[3:0];

  //////////////////////////////////////////////////
  // 6b sub-block
  //////////////////////////////////////////////////

  always_comb begin
    ones6 = $countones(s6);
    // First word after reset takes the disparity its 6b block implies
    rd_in = rd_known ? rd : rd_t'(ones6 < 3 || s6 == ~ENC6[7]);
    k28   = (s6 == K28_6B) || (s6 == ~K28_6B);
    hit6  = k28;
    x     = 5'd28;
    for (int i = 0; i < 32; i++) begin
      if (s6 == ENC6[i] || (s6 == ~ENC6[i] && ($countones(ENC6[i]) != 3 || i == 7))) begin
        x    = 5'(i);
        hit6 = 1'b1;
      end
    end
    // D.07 has a fixed form per disparity
    disp_err6 = (ones6 > 3 && rd_in) || (ones6 < 3 && !rd_in) ||
                (s6 == ENC6[7] && rd_in) || (s6 == ~ENC6[7] && !rd_in);
    rd_mid    = (ones6 == 3) ? rd_in : rd_t'(ones6 > 3);
  end

  //////////////////////////////////////////////////
  // 4b sub-block
  //////////////////////////////////////////////////

  always_comb begin
    ones4 = $countones(s4);
    a7    = (s4 == ALT7_4B) || (s4 == ~ALT7_4B);
    // Kx.7 share their 6b block with data
    kx7   = !k28 && (x == 5'd23 || x == 5'd27 || x == 5'd29 || x == 5'd30);
    d_a7  = x == 5'd11 || x == 5'd13 || x == 5'd14 ||
            x == 5'd17 || x == 5'd18 || x == 5'd20;
    y     = 3'd7;
    hit4  = 1'b0;
    if (k28) begin
      // Balanced K blocks are ambiguous without the disparity
      for (int j = 0; j < 8; j++) begin
        if (s4 == (rd_mid ? ~ENC4_K[j] : ENC4_K[j])) begin
          y    = 3'(j);
          hit4 = 1'b1;
        end
      end
    end else if (a7) begin
      hit4 = kx7 || d_a7;
    end else begin
      for (int j = 0; j < 8; j++) begin
        if (s4 == ENC4_D[j] || (s4 == ~ENC4_D[j] && ($countones(ENC4_D[j]) != 2 || j == 3))) begin
          y    = 3'(j);
          hit4 = 1'b1;
        end
      end
    end
    disp_err4 = (ones4 > 2 && rd_mid) || (ones4 < 2 && !rd_mid) ||
                (s4 == ENC4_D[3] && rd_mid) || (s4 == ~ENC4_D[3] && !rd_mid);
    rd_next   = (ones4 == 2) ? rd_mid : rd_t'(ones4 > 2);
  end

  assign word_d = '{
    data:   {y, x},
    k:      k28 || (a7 && kx7),
    status: {disp_err6 || disp_err4, !(hit6 && hit4)}
  };

  // Result one cycle after the strobe
  always_ff @(posedge ref_clk) begin
    if (rst) begin
      rd       <= 1'b0;
      rd_known <= 1'b0;
      valid    <= 1'b0;
    end else begin
      valid <= code_strobe;
      if (code_strobe) begin
        rd       <= rd_next;
        rd_known <= 1'b1;
      end
    end
  end

  always_ff @(posedge ref_clk) begin
    if (code_strobe) begin
      rx_word <= word_d;
    end
  end

endmodule

`default_nettype wire

/* logic/phy_top.sv */
`timescale 1ns/1ps
`default_nettype none

module phy_top (
  input  logic                ref_clk,
  input  logic                rst,
  input  phy_pkg::byte_t      mac_tx_data,
  input  logic                mac_tx_datak,
  input  logic                mac_data_en,
  input  logic                rx_polarity,
  input  logic                rx_in,
  output logic                tx_out_p,
  output logic                tx_out_n,
  output logic                word_tick,
  output phy_pkg::byte_t      rx_data,
  output logic                rx_datak,
  output phy_pkg::rx_status_t rx_status,
  output logic                rx_valid,
  output logic                rx_locked
);
  import phy_pkg::*;

  tx_word_t tx_word;
  rx_word_t rx_word;
  code_t    tx_code;
  code_t    rx_code;
  logic     idle;
  logic     rx_strobe;

  //////////////////////////////////////////////////
  // Transmit PCS
  //////////////////////////////////////////////////

  assign tx_word = '{data: mac_tx_data, k: mac_tx_datak};
  // No data offered means an idle comma
  assign idle    = ~mac_data_en;

  enc_8b10b u_enc (
    .ref_clk  (ref_clk),
    .rst      (rst),
    .word_tick(word_tick),
    .tx_word  (tx_word),
    .idle     (idle),
    .code     (tx_code)
  );

  tx_serializer u_ser (
    .ref_clk  (ref_clk),
    .rst      (rst),
    .code     (tx_code),
    .word_tick(word_tick),
    .tx_out_p (tx_out_p),
    .tx_out_n (tx_out_n)
  );

  //////////////////////////////////////////////////
  // Receive PCS
  //////////////////////////////////////////////////

  rx_aligner u_align (
    .ref_clk    (ref_clk),
    .rst        (rst),
    .rx_in      (rx_in),
    .rx_polarity(rx_polarity),
    .code       (rx_code),
    .code_strobe(rx_strobe),
    .locked     (rx_locked)
  );

  dec_8b10b u_dec (
    .ref_clk    (ref_clk),
    .rst        (rst),
    .code       (rx_code),
    .code_strobe(rx_strobe),
    .rx_word    (rx_word),
    .valid      (rx_valid)
  );

  // Unpack the decoded word
  assign rx_data   = rx_word.data;
  assign rx_datak  = rx_word.k;
  assign rx_status = rx_word.status;

endmodule

`default_nettype wire

/* tb/phy_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module phy_properties (
  input logic ref_clk,
  input logic rst,
  input logic tx_out_p,
  input logic tx_out_n,
  input logic word_tick,
  input logic rx_valid,
  input logic rx_locked
);

  logic [3:0] tick_gap;
  logic       line_live;
  logic       last_bit;
  logic [7:0] run_len;
  // Assertion failures so far
  int         assert_fails = 0;

  // Cycles since the last tick
  always_ff @(posedge ref_clk) begin
    if (rst || word_tick) begin
      tick_gap <= 4'd0;
    end else begin
      tick_gap <= tick_gap + 4'd1;
    end
  end

  // Run length of the line, counted from the first loaded word
  always_ff @(posedge ref_clk) begin
    if (rst) begin
      line_live <= 1'b0;
      last_bit  <= 1'b0;
      run_len   <= 8'd0;
    end else begin
      if (word_tick) begin
        line_live <= 1'b1;
      end
      if (line_live) begin
        last_bit <= tx_out_p;
        run_len  <= (run_len != 8'd0 && tx_out_p == last_bit) ? run_len + 8'd1 : 8'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Serial line and strobes
  //////////////////////////////////////////////////

  a_diff_pair: assert property (@(posedge ref_clk) disable iff (rst) tx_out_n == ~tx_out_p)
    else begin
      assert_fails++;
      $error("tx_out_n is not the complement of tx_out_p");
    end

  a_tick_period: assert property (@(posedge ref_clk) disable iff (rst)
    word_tick == (tick_gap == 4'd9))
    else begin
      assert_fails++;
      $error("word_tick period is not 10 cycles");
    end

  a_valid_locked: assert property (@(posedge ref_clk) disable iff (rst) rx_valid |-> rx_locked)
    else begin
      assert_fails++;
      $error("rx_valid pulsed while the receiver was unlocked");
    end

  a_run_length: assert property (@(posedge ref_clk) disable iff (rst) run_len <= 8'd5)
    else begin
      assert_fails++;
      $error("more than five equal bits in a row on the tx line");
    end

endmodule

bind phy_top phy_properties u_props (
  .ref_clk  (ref_clk),
  .rst      (rst),
  .tx_out_p (tx_out_p),
  .tx_out_n (tx_out_n),
  .word_tick(word_tick),
  .rx_valid (rx_valid),
  .rx_locked(rx_locked)
);

`default_nettype wire

/* tb/phy_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module phy_tb;
  import phy_pkg::*;

  // One expected word, tagged with the test that sent it
  typedef struct packed {
    byte_t      data;
    logic       k;
    logic       inject;
    logic [2:0] test_id;
  } exp_entry_t;

  localparam logic [2:0] TEST_LOCK     = 3'd0;
  localparam logic [2:0] TEST_RANDOM   = 3'd1;
  localparam logic [2:0] TEST_CONTROL  = 3'd2;
  localparam logic [2:0] TEST_POLARITY = 3'd3;
  localparam logic [2:0] TEST_INJECT   = 3'd4;

  logic       ref_clk;
  logic       rst;
  byte_t      mac_tx_data;
  logic       mac_tx_datak;
  logic       mac_data_en;
  logic       rx_polarity;
  logic       rx_in;
  logic       tx_out_p;
  logic       tx_out_n;
  logic       word_tick;
  byte_t      rx_data;
  logic       rx_datak;
  rx_status_t rx_status;
  logic       rx_valid;
  logic       rx_locked;

  exp_entry_t exp_q[$];
  logic [2:0] cur_test;
  logic       loop_invert;
  int         flip_requests;
  int         flips_done;
  int         cmp_errors;
  int         stim_errors;
  int         words_seen;
  int         idle_seen;
  int         inject_left;
  int         inject_hits;

  phy_top u_phy_top (
    .ref_clk     (ref_clk),
    .rst         (rst),
    .mac_tx_data (mac_tx_data),
    .mac_tx_datak(mac_tx_datak),
    .mac_data_en (mac_data_en),
    .rx_polarity (rx_polarity),
    .rx_in       (rx_in),
    .tx_out_p    (tx_out_p),
    .tx_out_n    (tx_out_n),
    .word_tick   (word_tick),
    .rx_data     (rx_data),
    .rx_datak    (rx_datak),
    .rx_status   (rx_status),
    .rx_valid    (rx_valid),
    .rx_locked   (rx_locked)
  );

  // 100 ns period
  initial begin
    ref_clk = 1'b0;
    forever #50 ref_clk = ~ref_clk;
  end

  //////////////////////////////////////////////////
  // Serial loopback with inversion and bit flip
  //////////////////////////////////////////////////

  initial begin : loopback
    logic tick_prev;
    rx_in      = 1'b0;
    flips_done = 0;
    tick_prev  = 1'b0;
    forever begin
      @(posedge ref_clk);
      #1;
      // Bit a of a word goes out the cycle after its tick
      if (tick_prev && flips_done < flip_requests) begin
        rx_in = ~(tx_out_p ^ loop_invert);
        flips_done++;
      end else begin
        rx_in = tx_out_p ^ loop_invert;
      end
      tick_prev = word_tick;
    end
  end

  //////////////////////////////////////////////////
  // Reference model and comparator
  //////////////////////////////////////////////////

  // Idle slots come back as K28.5, everything else as sent
  function automatic rx_word_t expected_word(input byte_t data, input logic k, input logic idle);
    rx_word_t w;
    w.data   = idle ? 8'hBC : data;
    w.k      = idle | k;
    w.status = 2'b00;
    return w;
  endfunction

  function automatic string test_label(input logic [2:0] id);
    string s;
    case (id)
      TEST_LOCK:     s = "reset_lock";
      TEST_RANDOM:   s = "random_data";
      TEST_CONTROL:  s = "control_chars";
      TEST_POLARITY: s = "polarity";
      TEST_INJECT:   s = "error_inject";
      default:       s = "unknown";
    endcase
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      cmp_errors++;
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  initial begin : compare
    exp_entry_t head;
    rx_word_t   exp_w;
    rx_word_t   got_w;
    logic       is_comma;
    logic       head_is_comma;
    cmp_errors  = 0;
    words_seen  = 0;
    idle_seen   = 0;
    inject_left = 0;
    inject_hits = 0;
    forever begin
      // Mid-cycle, the registered outputs are settled
      @(negedge ref_clk);
      if (rx_valid) begin
        got_w         = '{data: rx_data, k: rx_datak, status: rx_status};
        is_comma      = rx_datak && rx_data == 8'hBC;
        head_is_comma = exp_q.size() != 0 && exp_q[0].k && exp_q[0].data == 8'hBC;
        words_seen++;
        if (exp_q.size() == 0 || (is_comma && !head_is_comma)) begin
          // Idle comma between bursts
          exp_w = expected_word(8'h00, 1'b0, 1'b1);
          check_value({test_label(cur_test), " idle"}, 32'(exp_w), 32'(got_w));
          idle_seen++;
        end else begin
          head  = exp_q.pop_front();
          exp_w = expected_word(head.data, head.k, 1'b0);
          if (head.inject) begin
            inject_left = 2;
          end
          // Corrupted word or the one after may carry the error
          if (inject_left > 0 && got_w.status != 2'b00) begin
            inject_hits++;
          end else begin
            check_value(test_label(head.test_id), 32'(exp_w), 32'(got_w));
          end
          if (inject_left > 0) begin
            inject_left--;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // Present one word in the next tick cycle
  task automatic send_word(input byte_t data, input logic k, input logic inject);
    int         cycles;
    exp_entry_t e;
    cycles = 0;
    do begin
      @(posedge ref_clk);
      #1;
      cycles++;
    end while (!word_tick && cycles < 20);
    if (!word_tick) begin
      stim_errors++;
      $display("Timeout: no word_tick within 20 cycles");
    end else begin
      mac_tx_data  = data;
      mac_tx_datak = k;
      mac_data_en  = 1'b1;
      e = '{data: data, k: k, inject: inject, test_id: cur_test};
      exp_q.push_back(e);
      if (inject) begin
        flip_requests++;
      end
      // Back to idle unless the next call sends again
      @(posedge ref_clk);
      #1;
      mac_data_en = 1'b0;
    end
  endtask

  task automatic send_random(input int count);
    byte_t b;
    for (int i = 0; i < count; i++) begin
      b = 8'($urandom());
      send_word(b, 1'b0, 1'b0);
    end
  endtask

  task automatic wait_locked();
    int cycles;
    cycles = 0;
    // 100 words
    while (!rx_locked && cycles < 1000) begin
      @(posedge ref_clk);
      #1;
      cycles++;
    end
    if (!rx_locked) begin
      stim_errors++;
      $display("Timeout: receiver did not lock within 100 words");
    end
  endtask

  task automatic wait_words(input int count);
    int target;
    int cycles;
    target = words_seen + count;
    cycles = 0;
    while (words_seen < target && cycles < count * 10 + 40) begin
      @(posedge ref_clk);
      #1;
      cycles++;
    end
    if (words_seen < target) begin
      stim_errors++;
      $display("Timeout: fewer than %0d words decoded", count);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 400) begin
      @(posedge ref_clk);
      #1;
      cycles++;
    end
    if (exp_q.size() != 0) begin
      stim_errors++;
      $display("Timeout: %0d sent words never came back", exp_q.size());
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (5) @(posedge ref_clk);
    #1;
    rst = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    int prop_errors;
    int total;
    void'($urandom(32'h9566f424));
    rst           = 1'b1;
    mac_tx_data   = 8'h00;
    mac_tx_datak  = 1'b0;
    mac_data_en   = 1'b0;
    rx_polarity   = 1'b0;
    loop_invert   = 1'b0;
    flip_requests = 0;
    stim_errors   = 0;
    cur_test      = TEST_LOCK;
    apply_reset();

    // Idle commas only until the aligner locks
    wait_locked();
    wait_words(8);

    cur_test = TEST_RANDOM;
    send_random(200);
    wait_drain();

    // Controls kept apart from the idle comma so K28.5 sits mid-burst
    cur_test = TEST_CONTROL;
    send_word(8'hFB, 1'b1, 1'b0);
    send_word(8'h1C, 1'b1, 1'b0);
    send_word(8'hBC, 1'b1, 1'b0);
    send_word(8'hFD, 1'b1, 1'b0);
    wait_drain();

    // Inverted lane, compensated on the receive side
    cur_test = TEST_POLARITY;
    @(posedge ref_clk);
    #1;
    loop_invert = 1'b1;
    rx_polarity = 1'b1;
    apply_reset();
    wait_locked();
    wait_words(4);
    send_random(200);
    wait_drain();

    // Bit a of K28.5 flipped gives a 6b block outside the table
    cur_test = TEST_INJECT;
    send_word(8'hB5, 1'b0, 1'b0);
    send_word(8'hBC, 1'b1, 1'b1);
    send_word(8'hB5, 1'b0, 1'b0);
    send_word(8'hB5, 1'b0, 1'b0);
    wait_drain();
    wait_words(5);
    if (inject_hits == 0) begin
      stim_errors++;
      $display("Injected bit error was not flagged on rx_status");
    end

    prop_errors = u_phy_top.u_props.assert_fails;
    total       = cmp_errors + stim_errors + prop_errors;
    $display("Errors %0d, compare %0d, assertions %0d, other %0d, words %0d, idles %0d, flagged %0d",
             total, cmp_errors, prop_errors, stim_errors, words_seen, idle_seen,
             inject_hits);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/phy_pkg.sv
logic/enc_8b10b.sv
logic/tx_serializer.sv
logic/rx_aligner.sv
logic/dec_8b10b.sv
logic/phy_top.sv
tb/phy_properties.sv
tb/phy_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module phy_tb -o phy_sim
./obj_dir/phy_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
